/* common/ipic_pkg.sv */
// IPIC shared definitions

package ipic_pkg;

    // CSR data width
    localparam int IPIC_XLEN = 32;

    // ----------------------------
    // Register map
    // ----------------------------
    typedef enum logic [2:0] {
        IPIC_CISV = 3'd0,   // Current vector in service, read only
        IPIC_RSVD = 3'd1,   // Reserved, reads zero
        IPIC_IPR  = 3'd2,   // Pending lines, read only
        IPIC_ISVR = 3'd3,   // In-service lines, read only
        IPIC_EOI  = 3'd4,   // End of interrupt
        IPIC_SOI  = 3'd5,   // Start of interrupt
        IPIC_IDX  = 3'd6,   // Line select
        IPIC_ICSR = 3'd7    // Selected line control and status
    } ipic_addr_e;

    // ----------------------------
    // ICSR bit positions
    // ----------------------------
    localparam int ICSR_IP      = 0;   // Pending
    localparam int ICSR_IE      = 1;   // Enable
    localparam int ICSR_IM      = 2;   // Mode, 0 level and 1 edge
    localparam int ICSR_INV     = 3;   // Line inversion
    localparam int ICSR_IS      = 4;   // In service
    localparam int ICSR_PRV_LSB = 8;
    localparam int ICSR_PRV_MSB = 9;
    localparam int ICSR_LN_LSB  = 12;  // Line number field start

    localparam logic [1:0] IPIC_PRV_M = 2'd3;  // Machine privilege

    // CSR side request, all strobes in one cycle
    typedef struct packed {
        logic                 r_req;
        logic                 w_req;
        ipic_addr_e           addr;
        logic [IPIC_XLEN-1:0] wdata;
    } ipic_csr_req_t;

    // Decoded write strobes
    typedef struct packed {
        logic eoi;
        logic soi;
        logic idx;
        logic icsr;
    } ipic_wr_sel_t;

    // Status of the line picked by IDX
    typedef struct packed {
        logic ip;
        logic ie;
        logic im;
        logic inv;
        logic is;
    } ipic_line_stat_t;

endpackage

/* compile.f */
common/ipic_pkg.sv
src/ipic_line_front.sv
src/ipic_prio_find.sv
src/ipic_csr_port.sv
src/ipic_line_regs.sv
src/ipic_service.sv
src/ipic_top.sv
dv/ipic_tb.sv

/* dv/ipic_stim.txt */
# Columns: op addr data exp_rdata exp_irq, all hex
# W write, R read, L set lines to data, N idle data cycles, T end of test addr
R 0 0 10 0
R 2 0 0 0
R 3 0 0 0
R 7 0 300 0
R 6 0 0 0
T 1 0 0 0
W 6 5 0 0
W 7 2 0 0
R 7 0 5302 0
R 6 0 5 0
L 0 20 0 0
N 0 4 0 1
R 2 0 20 1
R 7 0 5303 1
W 6 6 0 1
W 7 8 0 1
R 2 0 60 1
R 7 0 6309 1
T 2 0 0 0
W 6 9 0 1
W 7 4 0 1
L 0 220 0 1
N 0 4 0 1
R 2 0 260 1
R 7 0 9305 1
L 0 20 0 1
N 0 4 0 1
R 2 0 260 1
W 7 5 0 1
R 2 0 60 1
R 7 0 9304 1
T 3 0 0 0
W 5 0 0 1
R 0 0 5 0
R 3 0 20 0
W 6 5 0 0
R 7 0 5313 0
W 6 2 0 0
W 7 6 0 0
L 0 24 0 0
N 0 4 0 1
R 2 0 64 1
W 5 0 0 1
R 0 0 2 0
R 3 0 24 0
R 2 0 60 0
T 4 0 0 0
W 4 0 0 0
R 0 0 5 0
R 3 0 20 0
W 1 ffff 0 0
W 2 ffff 0 0
R 1 0 0 0
R 2 0 60 0
R 3 0 20 0
R 4 0 0 0
R 5 0 0 0
W 4 0 0 0
R 0 0 10 1
R 3 0 0 1
T 5 0 0 0

/* dv/ipic_tb.sv */
// IPIC stimulus replay testbench
`timescale 1ns/1ps

module ipic_tb
    import ipic_pkg::*;
();

    localparam int    NUM_LINES  = 16;
    localparam int    RST_CYCLES = 5;
    localparam string STIM_FILE  = "dv/ipic_stim.txt";

    logic                 clk;
    logic                 rst_n;
    logic [NUM_LINES-1:0] irq_lines;
    ipic_csr_req_t        csr_req;
    logic [IPIC_XLEN-1:0] rdata;
    logic                 irq_m_req;

    int cycles      = 0;
    int cycle_limit = 0;   // Known once the file is scanned
    int errors      = 0;
    int test_errors = 0;   // Mismatches in the current test
    int checks      = 0;
    int fd;
    int code;

    logic [63:0]      op;               // Operation token
    logic [31:0]      addr, data, exp_rd, exp_irq;
    logic [8*128-1:0] skip_line;        // Rest of a comment line

    ipic_top #(.NUM_LINES(NUM_LINES), .SYNC_EN(1'b1)) UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_lines_i (irq_lines),
        .csr_req_i   (csr_req),
        .rdata_o     (rdata),
        .irq_m_req_o (irq_m_req)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;   // 4 ns period

    // Run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Stimulus did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ----------------------------
    // Helpers
    // ----------------------------
    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        checks = checks + 1;
        if (act_v !== exp_v) begin
            $display("Error at %t: %s expected %h, got %h", $time, name, exp_v, act_v);
            errors      = errors + 1;
            test_errors = test_errors + 1;
        end
    endtask

    // Sample late in the low phase
    task automatic check_outputs();
        #1;
        check_val("rdata_o", exp_rd, rdata);
        check_val("irq_m_req_o", exp_irq, {31'b0, irq_m_req});
    endtask

    task automatic drive_req(input logic rd, input logic wr, input logic [2:0] a,
                             input logic [31:0] d);
        @(negedge clk);
        csr_req.r_req = rd;
        csr_req.w_req = wr;
        csr_req.addr  = ipic_addr_e'(a);
        csr_req.wdata = d;
    endtask

    // Next record, comment lines skipped
    task automatic read_record(output bit got);
        bit done;
        got  = 1'b0;
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, "%s", op);
            if (code != 1) begin
                done = 1'b1;                   // End of file
            end else if (op == "#") begin
                code = $fgets(skip_line, fd);
            end else begin
                code = $fscanf(fd, "%h %h %h %h", addr, data, exp_rd, exp_irq);
                if (code != 4) begin
                    $display("Malformed record in the stimulus file");
                    errors = errors + 1;
                end else begin
                    got = 1'b1;
                end
                done = 1'b1;
            end
        end
    endtask

    task automatic run_op();
        case (op)
            "W": begin
                drive_req(1'b0, 1'b1, addr[2:0], data);
                check_outputs();
            end
            "R": begin
                drive_req(1'b1, 1'b0, addr[2:0], data);
                check_outputs();
            end
            "L": begin
                drive_req(1'b0, 1'b0, 3'd0, 32'd0);
                irq_lines = data[NUM_LINES-1:0];
                check_outputs();
            end
            "N": begin
                repeat (data) drive_req(1'b0, 1'b0, 3'd0, 32'd0);
                check_outputs();   // State after the idle stretch
            end
            "T": begin
                $display("Test %0d finished with %0d mismatches", addr, test_errors);
                test_errors = 0;
            end
            default: begin
                $display("Unknown operation in the stimulus file");
                errors = errors + 1;
            end
        endcase
    endtask

    // ----------------------------
    // Main sequence
    // ----------------------------
    initial begin
        bit got;
        int total;
        $timeformat(-9, 1, " ns", 0);
        irq_lines = '0;
        csr_req   = '0;
        rst_n     = 1'b0;
        total     = RST_CYCLES;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file %s", STIM_FILE);
            errors = errors + 1;
        end else begin
            // Scan once to size the run limit
            read_record(got);
            while (got) begin
                if (op == "N")      total = total + data;
                else if (op != "T") total = total + 1;
                read_record(got);
            end
            $fclose(fd);
        end
        cycle_limit = 2 * total;

        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        if (fd != 0) begin
            fd = $fopen(STIM_FILE, "r");
            read_record(got);
            while (got) begin
                run_op();
                read_record(got);
            end
            $fclose(fd);
        end

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* src/ipic_csr_port.sv */
// CSR window decode and read mux
`timescale 1ns/1ps

module ipic_csr_port
    import ipic_pkg::*;
#(
    parameter int NUM_LINES = 16
) (
    input  ipic_csr_req_t                csr_req_i,
    output ipic_wr_sel_t                 wr_sel_o,
    input  logic [$clog2(NUM_LINES)-1:0] idx_i,
    input  logic [NUM_LINES-1:0]         ipr_i,
    input  logic [NUM_LINES-1:0]         isvr_i,
    input  logic [$clog2(NUM_LINES):0]   cisv_i,
    input  ipic_line_stat_t              line_stat_i,
    output logic [IPIC_XLEN-1:0]         rdata_o
);

    localparam int IDX_W = $clog2(NUM_LINES);
    localparam int VEC_W = IDX_W + 1;

    // ----------------------------
    // Write strobes
    // ----------------------------
    always_comb begin
        wr_sel_o = '0;
        if (csr_req_i.w_req) begin
            case (csr_req_i.addr)
                IPIC_EOI:  wr_sel_o.eoi  = 1'b1;
                IPIC_SOI:  wr_sel_o.soi  = 1'b1;
                IPIC_IDX:  wr_sel_o.idx  = 1'b1;
                IPIC_ICSR: wr_sel_o.icsr = 1'b1;
                default:   wr_sel_o      = '0;  // Read only or reserved
            endcase
        end
    end

    // ----------------------------
    // Read data
    // ----------------------------
    always_comb begin
        rdata_o = '0;
        if (csr_req_i.r_req) begin
            case (csr_req_i.addr)
                IPIC_CISV: rdata_o[VEC_W-1:0] = cisv_i;
                IPIC_IPR:  rdata_o = IPIC_XLEN'(ipr_i);
                IPIC_ISVR: rdata_o = IPIC_XLEN'(isvr_i);
                IPIC_IDX:  rdata_o = IPIC_XLEN'(idx_i);
                IPIC_ICSR: begin
                    rdata_o[ICSR_IP]  = line_stat_i.ip;
                    rdata_o[ICSR_IE]  = line_stat_i.ie;
                    rdata_o[ICSR_IM]  = line_stat_i.im;
                    rdata_o[ICSR_INV] = line_stat_i.inv;
                    rdata_o[ICSR_IS]  = line_stat_i.is;
                    // Privilege is fixed to machine
                    rdata_o[ICSR_PRV_MSB:ICSR_PRV_LSB] = IPIC_PRV_M;
                    rdata_o[ICSR_LN_LSB +: IDX_W]      = idx_i;  // Line number
                end
                default:   rdata_o = '0;  // EOI, SOI, reserved
            endcase
        end
    end

endmodule

/* src/ipic_line_front.sv */
// IRQ line front end
`timescale 1ns/1ps

module ipic_line_front #(
    parameter int NUM_LINES = 16,
    parameter bit SYNC_EN   = 1'b1
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [NUM_LINES-1:0] irq_lines_i,  // Raw external lines
    input  logic [NUM_LINES-1:0] inv_i,        // Inversion, next value
    output logic [NUM_LINES-1:0] lvl_o,        // Active level per line
    output logic [NUM_LINES-1:0] edge_o        // Line just became active
);

    logic [NUM_LINES-1:0] lines;      // Lines after optional sync
    logic [NUM_LINES-1:0] lines_dly;  // One cycle older copy

    generate
        if (SYNC_EN) begin : g_sync
            logic [NUM_LINES-1:0] sync_q;  // First stage

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    sync_q <= '0;
                    lines  <= '0;
                end else begin
                    sync_q <= irq_lines_i;
                    lines  <= sync_q;
                end
            end
        end else begin : g_nosync
            assign lines = irq_lines_i;  // Lines already in clock domain
        end
    endgenerate

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) lines_dly <= '0;
        else        lines_dly <= lines;
    end

    assign lvl_o  = lines ^ inv_i;
    // Changed this cycle and now active
    assign edge_o = (lines ^ lines_dly) & lvl_o;

endmodule

/* src/ipic_line_regs.sv */
// Per-line control and pending registers
`timescale 1ns/1ps

module ipic_line_regs
    import ipic_pkg::*;
#(
    parameter int NUM_LINES = 16
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  ipic_wr_sel_t                 wr_sel_i,
    input  logic [IPIC_XLEN-1:0]         wdata_i,
    input  logic [NUM_LINES-1:0]         lvl_i,
    input  logic [NUM_LINES-1:0]         edge_i,
    input  logic                         start_i,      // SOI accepted
    input  logic [$clog2(NUM_LINES)-1:0] start_idx_i,  // Line being started
    input  logic [NUM_LINES-1:0]         isvr_i,
    output logic [NUM_LINES-1:0]         inv_next_o,
    output logic [$clog2(NUM_LINES)-1:0] idx_o,
    output logic [NUM_LINES-1:0]         ipr_o,
    output logic [NUM_LINES-1:0]         ier_o,
    output ipic_line_stat_t              line_stat_o
);

    localparam int IDX_W = $clog2(NUM_LINES);

    logic [IDX_W-1:0]     idx_q;
    logic [NUM_LINES-1:0] ipr_q, ier_q, imr_q, iinvr_q;
    logic [NUM_LINES-1:0] ipr_next, ier_next, imr_next, iinvr_next;
    logic [NUM_LINES-1:0] clr_req;  // Pending clear requests

    // ICSR write hits only the selected line
    always_comb begin
        ier_next   = ier_q;
        imr_next   = imr_q;
        iinvr_next = iinvr_q;
        if (wr_sel_i.icsr) begin
            ier_next[idx_q]   = wdata_i[ICSR_IE];
            imr_next[idx_q]   = wdata_i[ICSR_IM];
            iinvr_next[idx_q] = wdata_i[ICSR_INV];
        end
    end

    // ----------------------------
    // Pending update
    // ----------------------------
    always_comb begin
        clr_req = '0;
        if (wr_sel_i.icsr && wdata_i[ICSR_IP]) clr_req[idx_q] = 1'b1;
        if (start_i)                           clr_req[start_idx_i] = 1'b1;
    end

    always_comb begin
        for (int i = 0; i < NUM_LINES; i++) begin
            // Active level line cannot be cleared
            if (clr_req[i] && (!lvl_i[i] || imr_next[i])) ipr_next[i] = 1'b0;
            else if (!imr_q[i])                          ipr_next[i] = lvl_i[i];
            else                                         ipr_next[i] = ipr_q[i] | edge_i[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_q   <= '0;
            ipr_q   <= '0;
            ier_q   <= '0;
            imr_q   <= '0;
            iinvr_q <= '0;
        end else begin
            if (wr_sel_i.idx) idx_q <= wdata_i[IDX_W-1:0];
            ipr_q   <= ipr_next;
            ier_q   <= ier_next;
            imr_q   <= imr_next;
            iinvr_q <= iinvr_next;
        end
    end

    assign inv_next_o = iinvr_next;  // Front end sees new inversion at once
    assign idx_o      = idx_q;
    assign ipr_o      = ipr_q;
    assign ier_o      = ier_q;

    assign line_stat_o.ip  = ipr_q[idx_q];
    assign line_stat_o.ie  = ier_q[idx_q];
    assign line_stat_o.im  = imr_q[idx_q];
    assign line_stat_o.inv = iinvr_q[idx_q];
    assign line_stat_o.is  = isvr_i[idx_q];

endmodule

/* src/ipic_prio_find.sv */
// Lowest set bit search
`timescale 1ns/1ps

module ipic_prio_find #(
    parameter int NUM_LINES = 16
) (
    input  logic [NUM_LINES-1:0]         vec_i,
    output logic                         vd_o,   // Any bit set
    output logic [$clog2(NUM_LINES)-1:0] idx_o   // Lowest set bit
);

    localparam int IDX_W = $clog2(NUM_LINES);

    logic [NUM_LINES-1:0] vd_lvl  [IDX_W+1];              // Valid per tree node
    logic [IDX_W-1:0]     idx_lvl [IDX_W+1][NUM_LINES];   // Index per tree node

    always_comb begin
        for (int l = 0; l <= IDX_W; l++) begin
            vd_lvl[l] = '0;
            for (int j = 0; j < NUM_LINES; j++) idx_lvl[l][j] = '0;
        end
        vd_lvl[0] = vec_i;
        // Pairwise merge, lower half wins
        for (int l = 0; l < IDX_W; l++) begin
            for (int j = 0; j < (NUM_LINES >> (l + 1)); j++) begin
                vd_lvl[l+1][j]     = vd_lvl[l][2*j] | vd_lvl[l][2*j+1];
                idx_lvl[l+1][j]    = vd_lvl[l][2*j] ? idx_lvl[l][2*j] : idx_lvl[l][2*j+1];
                idx_lvl[l+1][j][l] = ~vd_lvl[l][2*j];  // Upper half taken
            end
        end
    end

    assign vd_o  = vd_lvl[IDX_W][0];
    assign idx_o = idx_lvl[IDX_W][0];

endmodule

/* src/ipic_service.sv */
// In-service tracking and interrupt request
`timescale 1ns/1ps

module ipic_service
    import ipic_pkg::*;
#(
    parameter int NUM_LINES = 16
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  ipic_wr_sel_t                 wr_sel_i,
    input  logic [NUM_LINES-1:0]         ipr_i,
    input  logic [NUM_LINES-1:0]         ier_i,
    output logic [NUM_LINES-1:0]         isvr_o,
    output logic [$clog2(NUM_LINES):0]   cisv_o,
    output logic                         start_o,
    output logic [$clog2(NUM_LINES)-1:0] start_idx_o,
    output logic                         irq_m_req_o
);

    localparam int               IDX_W     = $clog2(NUM_LINES);
    localparam int               VEC_W     = IDX_W + 1;
    localparam logic [VEC_W-1:0] VOID_VECT = VEC_W'(NUM_LINES);  // Nothing in service

    logic [VEC_W-1:0]     cisv_q;
    logic [NUM_LINES-1:0] isvr_q;
    logic [NUM_LINES-1:0] isvr_eoi;   // ISVR minus current one
    logic                 serv_vd;
    logic [IDX_W-1:0]     serv_idx;
    logic                 req_vd, eoi_vd;
    logic [IDX_W-1:0]     req_idx, eoi_idx;
    logic                 eoi_req;

    assign serv_vd  = ~cisv_q[VEC_W-1];  // Void vector has the top bit set
    assign serv_idx = cisv_q[IDX_W-1:0];

    always_comb begin
        isvr_eoi = isvr_q;
        if (serv_vd) isvr_eoi[serv_idx] = 1'b0;
    end

    // Best pending and enabled line
    ipic_prio_find #(.NUM_LINES(NUM_LINES)) u_req_find (
        .vec_i (ipr_i & ier_i),
        .vd_o  (req_vd),
        .idx_o (req_idx)
    );

    // Outer interrupt to resume on EOI
    ipic_prio_find #(.NUM_LINES(NUM_LINES)) u_eoi_find (
        .vec_i (isvr_eoi),
        .vd_o  (eoi_vd),
        .idx_o (eoi_idx)
    );

    assign irq_m_req_o = req_vd & (~serv_vd | (req_idx < serv_idx));
    assign start_o     = wr_sel_i.soi & irq_m_req_o;
    assign start_idx_o = req_idx;
    assign eoi_req     = wr_sel_i.eoi & serv_vd;  // EOI with nothing in service is ignored

    // ----------------------------
    // CISV and ISVR
    // ----------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cisv_q <= VOID_VECT;
            isvr_q <= '0;
        end else if (start_o) begin
            cisv_q          <= {1'b0, req_idx};
            isvr_q[req_idx] <= 1'b1;
        end else if (eoi_req) begin
            cisv_q <= eoi_vd ? {1'b0, eoi_idx} : VOID_VECT;
            isvr_q <= isvr_eoi;
        end
    end

    assign isvr_o = isvr_q;
    assign cisv_o = cisv_q;

endmodule

/* src/ipic_top.sv */
// IPIC top level
`timescale 1ns/1ps

module ipic_top
    import ipic_pkg::*;
#(
    parameter int NUM_LINES = 16,
    parameter bit SYNC_EN   = 1'b1
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [NUM_LINES-1:0] irq_lines_i,
    input  ipic_csr_req_t        csr_req_i,
    output logic [IPIC_XLEN-1:0] rdata_o,
    output logic                 irq_m_req_o   // Machine external interrupt
);

    localparam int IDX_W = $clog2(NUM_LINES);

    logic [NUM_LINES-1:0] irq_lvl, irq_edge, inv_next;
    logic [NUM_LINES-1:0] ipr, ier, isvr;
    logic [IDX_W-1:0]     idx, start_idx;
    logic [IDX_W:0]       cisv;
    logic                 start;
    ipic_wr_sel_t         wr_sel;
    ipic_line_stat_t      line_stat;

    ipic_line_front #(.NUM_LINES(NUM_LINES), .SYNC_EN(SYNC_EN)) u_front (
        .clk, .rst_n,
        .irq_lines_i (irq_lines_i),
        .inv_i       (inv_next),
        .lvl_o       (irq_lvl),
        .edge_o      (irq_edge)
    );

    ipic_csr_port #(.NUM_LINES(NUM_LINES)) u_csr (
        .csr_req_i   (csr_req_i),
        .wr_sel_o    (wr_sel),
        .idx_i       (idx),
        .ipr_i       (ipr),
        .isvr_i      (isvr),
        .cisv_i      (cisv),
        .line_stat_i (line_stat),
        .rdata_o     (rdata_o)
    );

    ipic_line_regs #(.NUM_LINES(NUM_LINES)) u_regs (
        .clk, .rst_n,
        .wr_sel_i    (wr_sel),
        .wdata_i     (csr_req_i.wdata),
        .lvl_i       (irq_lvl),
        .edge_i      (irq_edge),
        .start_i     (start),
        .start_idx_i (start_idx),
        .isvr_i      (isvr),
        .inv_next_o  (inv_next),
        .idx_o       (idx),
        .ipr_o       (ipr),
        .ier_o       (ier),
        .line_stat_o (line_stat)
    );

    ipic_service #(.NUM_LINES(NUM_LINES)) u_serv (
        .clk, .rst_n,
        .wr_sel_i    (wr_sel),
        .ipr_i       (ipr),
        .ier_i       (ier),
        .isvr_o      (isvr),
        .cisv_o      (cisv),
        .start_o     (start),
        .start_idx_o (start_idx),
        .irq_m_req_o (irq_m_req_o)
    );

endmodule
